//--- hdl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alu_issue,
    input  rv32i_types_pkg::instr_t       issue_inst,
    input  logic [backend_pkg::xlen-1:0]  issue_a,
    input  logic [backend_pkg::xlen-1:0]  issue_b,
    input  logic [$clog2(ROB_DEPTH)-1:0]  issue_tag,
    input  logic                          alu_grant,
    output logic                          alu_busy,
    output logic                          alu_done,
    output logic [$clog2(ROB_DEPTH)-1:0]  alu_tag,
    output logic [backend_pkg::xlen-1:0]  alu_result
);

    import rv32i_types_pkg::*;
    import backend_pkg::*;

    logic                    is_op;
    logic                    is_alt;
    logic [4:0]              shamt;
    logic signed [xlen-1:0]  sra_val;
    logic [xlen-1:0]         result_d;

    assign is_op   = (issue_inst.r_type.opcode == op_b_reg);
    assign is_alt  = (issue_inst.r_type.funct7 == f7_alt);
    assign shamt   = issue_b[4:0];
    assign sra_val = $signed(issue_a) >>> shamt;

    always_comb begin
        result_d = '0;
        case (issue_inst.r_type.funct3)
            f3_add: begin
                // addi has no sub form
                if (is_op && is_alt) begin
                    result_d = issue_a - issue_b;
                end else begin
                    result_d = issue_a + issue_b;
                end
            end
            f3_sll:  result_d = issue_a << shamt;
            f3_slt:  result_d = {{(xlen-1){1'b0}}, ($signed(issue_a) < $signed(issue_b))};
            f3_sltu: result_d = {{(xlen-1){1'b0}}, (issue_a < issue_b)};
            f3_xor:  result_d = issue_a ^ issue_b;
            f3_sr: begin
                // srai keeps the alt bit in imm[11:5]
                if (is_alt) begin
                    result_d = sra_val;
                end else begin
                    result_d = issue_a >> shamt;
                end
            end
            f3_or:   result_d = issue_a | issue_b;
            f3_and:  result_d = issue_a & issue_b;
            default: result_d = '0;
        endcase
    end

    // holding register empties on grant
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_done <= 1'b0;
        end else if (alu_issue) begin
            alu_done <= 1'b1;
        end else if (alu_grant) begin
            alu_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_result <= result_d;
            alu_tag    <= issue_tag;
        end
    end

    // a granted result frees the slot for a new issue
    assign alu_busy = alu_done && !alu_grant;

endmodule

`default_nettype wire

//--- hdl/backend_pkg.sv
`default_nettype none

package backend_pkg;

    // datapath width
    localparam int xlen = 32;

    // retirement order counter
    localparam int order_width = 64;

endpackage

`default_nettype wire

//--- hdl/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alu_done,
    input  logic [$clog2(ROB_DEPTH)-1:0]  alu_tag,
    input  logic [backend_pkg::xlen-1:0]  alu_result,
    input  logic                          mul_done,
    input  logic [$clog2(ROB_DEPTH)-1:0]  mul_tag,
    input  logic [backend_pkg::xlen-1:0]  mul_result,
    output logic                          alu_grant,
    output logic                          mul_grant,
    output logic                          cdb_valid,
    output logic [$clog2(ROB_DEPTH)-1:0]  cdb_tag,
    output logic [backend_pkg::xlen-1:0]  cdb_data
);

    // set when the multiplier took the last contested cycle
    logic last_mul;

    assign alu_grant = alu_done && (!mul_done || last_mul);
    assign mul_grant = mul_done && (!alu_done || !last_mul);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mul <= 1'b0;
        end else if (alu_done && mul_done) begin
            last_mul <= mul_grant;
        end
    end

    // winner drives the bus
    assign cdb_valid = alu_grant || mul_grant;
    assign cdb_tag   = mul_grant ? mul_tag : alu_tag;
    assign cdb_data  = mul_grant ? mul_result : alu_result;

endmodule

`default_nettype wire

//--- hdl/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
    parameter int ROB_DEPTH  = 8,
    parameter int MUL_STAGES = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mul_issue,
    input  logic [backend_pkg::xlen-1:0]  issue_a,
    input  logic [backend_pkg::xlen-1:0]  issue_b,
    input  logic [$clog2(ROB_DEPTH)-1:0]  issue_tag,
    input  logic                          mul_grant,
    output logic                          mul_busy,
    output logic                          mul_done,
    output logic [$clog2(ROB_DEPTH)-1:0]  mul_tag,
    output logic [backend_pkg::xlen-1:0]  mul_result
);

    import backend_pkg::*;

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int LAST  = MUL_STAGES - 1;

    logic [MUL_STAGES-1:0]  stage_valid;
    logic [TAG_W-1:0]       stage_tag  [MUL_STAGES];
    logic [xlen-1:0]        stage_data [MUL_STAGES];
    logic                   advance;
    logic [xlen-1:0]        product;

    // low word only, same for signed and unsigned
    assign product = issue_a * issue_b;

    // whole pipe moves when the last stage drains or is empty
    assign advance  = !stage_valid[LAST] || mul_grant;
    assign mul_busy = !advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid[0] <= mul_issue;
            for (int i = 1; i < MUL_STAGES; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            stage_data[0] <= product;
            stage_tag[0]  <= issue_tag;
            for (int i = 1; i < MUL_STAGES; i++) begin
                stage_data[i] <= stage_data[i-1];
                stage_tag[i]  <= stage_tag[i-1];
            end
        end
    end

    assign mul_done   = stage_valid[LAST];
    assign mul_tag    = stage_tag[LAST];
    assign mul_result = stage_data[LAST];

endmodule

`default_nettype wire

//--- hdl/ooo_backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_backend_top #(
    parameter int ROB_DEPTH  = 8,
    parameter int MUL_STAGES = 3
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                dispatch_valid,
    input  logic [31:0]                         inst,
    input  logic [31:0]                         pc,
    input  logic [backend_pkg::xlen-1:0]        rs1_data,
    input  logic [backend_pkg::xlen-1:0]        rs2_data,
    output logic                                ready,
    output logic                                commit_valid,
    output logic [31:0]                         commit_pc,
    output logic [backend_pkg::order_width-1:0] commit_order,
    output logic [4:0]                          commit_rd,
    output logic [backend_pkg::xlen-1:0]        commit_data
);

    import rv32i_types_pkg::*;
    import backend_pkg::*;

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // issue bus shared by both units
    logic             alu_issue;
    logic             mul_issue;
    instr_t           issue_inst;
    logic [xlen-1:0]  issue_a;
    logic [xlen-1:0]  issue_b;
    logic [TAG_W-1:0] issue_tag;

    // unit completions
    logic             alu_busy;
    logic             alu_done;
    logic [TAG_W-1:0] alu_tag;
    logic [xlen-1:0]  alu_result;
    logic             mul_busy;
    logic             mul_done;
    logic [TAG_W-1:0] mul_tag;
    logic [xlen-1:0]  mul_result;

    // common data bus
    logic             alu_grant;
    logic             mul_grant;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    logic [xlen-1:0]  cdb_data;

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (.inst(inst), .*);

    alu_unit #(.ROB_DEPTH(ROB_DEPTH)) u_alu_unit (.*);

    mul_unit #(.ROB_DEPTH(ROB_DEPTH), .MUL_STAGES(MUL_STAGES)) u_mul_unit (.*);

    cdb_arbiter #(.ROB_DEPTH(ROB_DEPTH)) u_cdb_arbiter (.*);

endmodule

`default_nettype wire

//--- hdl/rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst,

    // dispatch
    input  logic                                dispatch_valid,
    input  rv32i_types_pkg::instr_t             inst,
    input  logic [31:0]                         pc,
    input  logic [backend_pkg::xlen-1:0]        rs1_data,
    input  logic [backend_pkg::xlen-1:0]        rs2_data,
    output logic                                ready,

    // issue to the units
    input  logic                                alu_busy,
    input  logic                                mul_busy,
    output logic                                alu_issue,
    output logic                                mul_issue,
    output rv32i_types_pkg::instr_t             issue_inst,
    output logic [backend_pkg::xlen-1:0]        issue_a,
    output logic [backend_pkg::xlen-1:0]        issue_b,
    output logic [$clog2(ROB_DEPTH)-1:0]        issue_tag,

    // writeback from the cdb
    input  logic                                cdb_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0]        cdb_tag,
    input  logic [backend_pkg::xlen-1:0]        cdb_data,

    // retirement
    output logic                                commit_valid,
    output logic [31:0]                         commit_pc,
    output logic [backend_pkg::order_width-1:0] commit_order,
    output logic [4:0]                          commit_rd,
    output logic [backend_pkg::xlen-1:0]        commit_data
);

    import rv32i_types_pkg::*;
    import backend_pkg::*;

    localparam int PTR_W = $clog2(ROB_DEPTH);

    // extra msb tells full from empty
    logic [PTR_W:0]          head;
    logic [PTR_W:0]          tail;
    logic [PTR_W-1:0]        head_idx;
    logic [PTR_W-1:0]        tail_idx;
    logic                    full;

    logic                    is_mul;
    logic                    is_imm;
    logic                    accept;
    logic [xlen-1:0]         imm_ext;

    logic [31:0]             entry_pc     [ROB_DEPTH];
    logic [4:0]              entry_rd     [ROB_DEPTH];
    logic [xlen-1:0]         entry_result [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]    entry_done;

    logic [order_width-1:0]  order_cnt;

    assign head_idx = head[PTR_W-1:0];
    assign tail_idx = tail[PTR_W-1:0];
    assign full     = (head[PTR_W] != tail[PTR_W]) && (head_idx == tail_idx);

    // only mul under OP goes to the multiplier
    assign is_mul  = (inst.r_type.opcode == op_b_reg) && (inst.r_type.funct7 == f7_muldiv);
    assign is_imm  = (inst.i_type.opcode == op_b_imm);
    assign imm_ext = {{(xlen-12){inst.i_type.imm[11]}}, inst.i_type.imm};

    // the target unit must be free this cycle too
    assign ready     = !full && (is_mul ? !mul_busy : !alu_busy);
    assign accept    = dispatch_valid && ready;
    assign alu_issue = accept && !is_mul;
    assign mul_issue = accept && is_mul;

    assign issue_inst = inst;
    assign issue_a    = rs1_data;
    assign issue_b    = is_imm ? imm_ext : rs2_data;
    assign issue_tag  = tail_idx;

    // head retires as soon as its result is in
    assign commit_valid = entry_done[head_idx];
    assign commit_pc    = entry_pc[head_idx];
    assign commit_rd    = entry_rd[head_idx];
    assign commit_data  = entry_result[head_idx];
    assign commit_order = order_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            entry_done <= '0;
            order_cnt  <= '0;
        end else begin
            if (accept) begin
                tail <= tail + 1'b1;
            end
            // cdb never targets the head while it is retiring
            if (cdb_valid) begin
                entry_done[cdb_tag] <= 1'b1;
            end
            if (commit_valid) begin
                head                 <= head + 1'b1;
                entry_done[head_idx] <= 1'b0;
                order_cnt            <= order_cnt + 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (accept) begin
            entry_pc[tail_idx] <= pc;
            entry_rd[tail_idx] <= inst.r_type.rd;
        end
        if (cdb_valid) begin
            entry_result[cdb_tag] <= cdb_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv32i_types_pkg.sv
`default_nettype none

package rv32i_types_pkg;

    // major opcodes handled by the back end
    localparam logic [6:0] op_b_reg = 7'b0110011;
    localparam logic [6:0] op_b_imm = 7'b0010011;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [6:0] f7_base   = 7'b0000000;
    // sub and sra
    localparam logic [6:0] f7_alt    = 7'b0100000;
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // same instruction word, decoded by opcode
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
    } instr_t;

endpackage

`default_nettype wire

//--- tb/ooo_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_backend_tb;

    import rv32i_types_pkg::*;

    localparam int rob_depth   = 8;
    localparam int mul_stages  = 3;
    // directed, mul, random, contention and fill tests
    localparam int total_instr = 26 + 10 + 200 + 48 + 16;
    localparam int cycle_limit = 20 * total_instr + 100;

    logic        clk;
    logic        rst;
    logic        dispatch_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        ready;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic [63:0] commit_order;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    integer      seed;
    int          check_cnt = 0;
    int          fail_cnt = 0;
    int          accept_cnt = 0;
    int          commit_cnt = 0;
    int          collide_cnt = 0;
    int          stall_cnt = 0;
    int          cycle_cnt;
    logic [63:0] exp_order = '0;
    logic [31:0] next_pc = 32'h0000_1000;
    logic [4:0]  next_rd = 5'd1;

    // expected retirement stream, in dispatch order
    logic [31:0] pc_q[$];
    logic [4:0]  rd_q[$];
    logic [31:0] data_q[$];

    ooo_backend_top #(
        .ROB_DEPTH(rob_depth),
        .MUL_STAGES(mul_stages)
    ) u_ooo_backend_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // RV32I result from the instruction word and both operands
    function automatic logic [31:0] ref_result(input logic [31:0] ins, input logic [31:0] a,
                                               input logic [31:0] r2);
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic [31:0]        res;
        b   = (ins[6:0] == op_b_imm) ? {{20{ins[31]}}, ins[31:20]} : r2;
        sa  = a;
        res = '0;
        if (ins[6:0] == op_b_reg && ins[31:25] == f7_muldiv) begin
            res = a * b;
        end else begin
            case (ins[14:12])
                f3_add:  res = (ins[6:0] == op_b_reg && ins[30]) ? a - b : a + b;
                f3_sll:  res = a << b[4:0];
                f3_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                f3_sltu: res = (a < b) ? 32'd1 : 32'd0;
                f3_xor:  res = a ^ b;
                f3_sr: begin
                    if (ins[30]) begin
                        res = sa >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                f3_or:   res = a | b;
                default: res = a & b;
            endcase
        end
        return res;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd0, op_b_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd0, op_b_imm};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_cnt++;
        assert (expected === actual) else begin
            $display("FAIL time=%0t %s expected %h got %h", $time, name, expected, actual);
            fail_cnt++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_cnt++;
        assert (cond) else begin
            $display("ERROR time=%0t %s", $time, what);
            fail_cnt++;
        end
    endtask

    // holds the instruction until the edge that takes it
    task automatic send(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
        logic taken;
        dispatch_valid = 1'b1;
        inst           = {ins[31:12], next_rd, ins[6:0]};
        pc             = next_pc;
        rs1_data       = a;
        rs2_data       = b;
        taken          = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = ready;
            @(posedge clk);
            #1;
        end
        next_pc = next_pc + 32'd4;
        next_rd = next_rd + 5'd3;
    endtask

    task automatic idle(input int n);
        dispatch_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        dispatch_valid = 1'b0;
        while (commit_cnt != accept_cnt) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic random_instr(output logic [31:0] ins);
        int          kind;
        logic [2:0]  f3;
        logic [4:0]  sh;
        logic        alt;
        logic [11:0] imm;
        kind = {$random(seed)} % 4;
        f3   = $random(seed);
        sh   = $random(seed);
        alt  = $random(seed);
        imm  = $random(seed);
        if (kind == 0) begin
            ins = enc_r(f7_muldiv, f3_add);
        end else if (kind == 1) begin
            ins = enc_r((alt && (f3 == f3_add || f3 == f3_sr)) ? f7_alt : f7_base, f3);
        end else begin
            // shifts keep a legal upper immediate
            if (f3 == f3_sll) begin
                imm = {7'b0, sh};
            end else if (f3 == f3_sr) begin
                imm = {alt ? f7_alt : f7_base, sh};
            end
            ins = enc_i(imm, f3);
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s finished with %0d errors", name, fail_cnt - fails_before);
    endtask

    // watch the dispatch and commit ports between edges
    always @(negedge clk) begin
        if (!rst) begin
            check_true(accept_cnt - commit_cnt <= rob_depth, "more instructions held than entries");
            if (accept_cnt - commit_cnt == rob_depth) begin
                check_true(!ready, "ready stayed high with every entry outstanding");
            end
            if (u_ooo_backend_top.alu_done && u_ooo_backend_top.mul_done) begin
                collide_cnt++;
            end
            if (dispatch_valid && !ready) begin
                stall_cnt++;
            end
            if (commit_valid) begin
                if (pc_q.size() == 0) begin
                    check_true(1'b0, "commit arrived with no instruction outstanding");
                end else begin
                    check_value("commit_pc", pc_q.pop_front(), commit_pc);
                    check_value("commit_rd", rd_q.pop_front(), commit_rd);
                    check_value("commit_data", data_q.pop_front(), commit_data);
                    check_value("commit_order", exp_order, commit_order);
                end
                exp_order = exp_order + 64'd1;
                commit_cnt++;
            end
            if (dispatch_valid && ready) begin
                pc_q.push_back(pc);
                rd_q.push_back(inst[11:7]);
                data_q.push_back(ref_result(inst, rs1_data, rs2_data));
                accept_cnt++;
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("ERROR commits stopped arriving, run stopped after %0d cycles", cycle_cnt);
        $display("checks passed %0d, failed %0d", check_cnt - fail_cnt, fail_cnt + 1);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0] ins;
        int          fails0;
        int          mark;
        logic [63:0] order0;
        seed           = 32'h0ad9_3514;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        inst           = '0;
        pc             = '0;
        rs1_data       = '0;
        rs2_data       = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("ready", 1, ready);
        check_value("commit_valid", 0, commit_valid);
        @(posedge clk);
        #1;

        // ALU ops on edge operands
        fails0 = fail_cnt;
        send(enc_r(f7_base, f3_add), 32'h7fff_ffff, 32'h1);
        send(enc_r(f7_alt, f3_add), 32'h0, 32'h1);
        send(enc_r(f7_alt, f3_add), 32'h8000_0000, 32'h1);
        send(enc_r(f7_base, f3_sll), 32'h1, 32'd31);
        send(enc_r(f7_base, f3_sll), 32'hdead_beef, 32'h24);
        send(enc_r(f7_base, f3_slt), 32'hffff_ffff, 32'h1);
        send(enc_r(f7_base, f3_slt), 32'h1, 32'hffff_ffff);
        send(enc_r(f7_base, f3_sltu), 32'hffff_ffff, 32'h1);
        send(enc_r(f7_base, f3_sltu), 32'h0, 32'hffff_ffff);
        send(enc_r(f7_base, f3_xor), 32'ha5a5_a5a5, 32'hffff_0000);
        send(enc_r(f7_base, f3_sr), 32'h8000_0000, 32'd31);
        send(enc_r(f7_alt, f3_sr), 32'h8000_0000, 32'd31);
        send(enc_r(f7_alt, f3_sr), 32'h7fff_ffff, 32'd4);
        send(enc_r(f7_base, f3_or), 32'h0f0f_0000, 32'h00f0_f0f0);
        send(enc_r(f7_base, f3_and), 32'hffff_00ff, 32'h0ff0_0ff0);
        send(enc_i(12'hfff, f3_add), 32'h0, 32'h5555_5555);
        send(enc_i(12'h800, f3_add), 32'h7fff_ffff, 32'h0);
        send(enc_i(12'h001, f3_slt), 32'hffff_ffff, 32'h0);
        send(enc_i(12'hfff, f3_sltu), 32'h5, 32'h0);
        send(enc_i(12'hfff, f3_xor), 32'h1234_5678, 32'h0);
        send(enc_i(12'h0f0, f3_or), 32'h0, 32'hffff_ffff);
        send(enc_i(12'h7ff, f3_and), 32'hffff_ffff, 32'h0);
        send(enc_i({7'b0, 5'd31}, f3_sll), 32'h3, 32'h0);
        send(enc_i({7'b0, 5'd8}, f3_sr), 32'h8000_0000, 32'h0);
        send(enc_i({f7_alt, 5'd8}, f3_sr), 32'h8000_0000, 32'h0);
        // bit 30 set in an addi immediate still adds
        send(enc_i(12'h420, f3_add), 32'd100, 32'h0);
        drain();
        report_test("alu_ops", fails0);

        // multiplies ahead of fast ALU ops
        fails0 = fail_cnt;
        send(enc_r(f7_muldiv, f3_add), 32'hffff_ffff, 32'hffff_ffff);
        send(enc_r(f7_muldiv, f3_add), 32'h8000_0000, 32'h2);
        send(enc_r(f7_muldiv, f3_add), 32'h1234_5678, 32'h9abc_def0);
        send(enc_r(f7_muldiv, f3_add), 32'hffff_fffe, 32'h3);
        send(enc_r(f7_muldiv, f3_add), 32'h7, 32'h6);
        send(enc_r(f7_base, f3_add), 32'h1, 32'h2);
        send(enc_i(12'h010, f3_add), 32'h20, 32'h0);
        send(enc_r(f7_base, f3_xor), 32'hff00_ff00, 32'h0ff0_0ff0);
        send(enc_r(f7_alt, f3_add), 32'h10, 32'h20);
        send(enc_r(f7_base, f3_or), 32'h1, 32'h8000_0000);
        drain();
        report_test("mul_order", fails0);

        // random mix with gaps in dispatch
        fails0 = fail_cnt;
        for (int k = 0; k < 200; k++) begin
            random_instr(ins);
            send(ins, $random(seed), $random(seed));
            if ({$random(seed)} % 5 == 0) begin
                idle(1);
            end
        end
        drain();
        report_test("random_mix", fails0);

        // mul, alu, alu lines both units up on the bus
        fails0 = fail_cnt;
        mark   = collide_cnt;
        for (int k = 0; k < 16; k++) begin
            send(enc_r(f7_muldiv, f3_add), $random(seed), $random(seed));
            send(enc_r(f7_base, f3_add), $random(seed), $random(seed));
            send(enc_r(f7_base, f3_xor), $random(seed), $random(seed));
        end
        drain();
        check_true(collide_cnt > mark, "no cycle had both units done at once");
        report_test("cdb_contention", fails0);

        // continuous dispatch behind a multiply
        fails0 = fail_cnt;
        mark   = stall_cnt;
        order0 = commit_order;
        send(enc_r(f7_muldiv, f3_add), $random(seed), $random(seed));
        for (int k = 0; k < 15; k++) begin
            send(enc_r(f7_base, f3_add), $random(seed), $random(seed));
        end
        drain();
        // one retirement per instruction sent
        check_value("commit_order", order0 + 64'd16, commit_order);
        check_true(stall_cnt > mark, "ready never dropped while dispatch was held");
        report_test("dispatch_hold", fails0);

        $display("checks passed %0d, failed %0d", check_cnt - fail_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/rv32i_types_pkg.sv
hdl/backend_pkg.sv
hdl/rob.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/cdb_arbiter.sv
hdl/ooo_backend_top.sv
tb/ooo_backend_tb.sv
